/* hw/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Immediate payload is inst[31:12], so the I field sits at bits 19:8
    typedef enum logic [1:0] {
        imm_i12  = 2'd0,
        imm_u20  = 2'd1,
        imm_sh5  = 2'd2,
        imm_none = 2'd3
    } imm_kind_e;

    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    typedef enum logic {
        src2_imm = 1'b0,
        src2_rs2 = 1'b1
    } src2_sel_e;

endpackage

/* hw/id_ex_if.sv */
interface id_ex_if #(
    parameter int data_w = rv_pkg::xlen,
    parameter int addr_w = rv_pkg::reg_addr_w
);
    import rv_pkg::*;

    logic              valid;
    logic              ready;
    logic [data_w-1:0] pc;
    logic [data_w-1:0] inst;
    logic [data_w-1:0] rs1_value;
    logic [data_w-1:0] rs2_value;
    logic [data_w-1:0] imm;       // Raw inst[31:12], right-aligned
    imm_kind_e         imm_kind;
    alu_op_e           alu_op;
    src1_sel_e         src1_sel;
    src2_sel_e         src2_sel;
    logic [addr_w-1:0] rd;
    logic              rd_wen;

    modport decode (
        output valid, pc, inst, rs1_value, rs2_value, imm, imm_kind,
               alu_op, src1_sel, src2_sel, rd, rd_wen,
        input  ready
    );

    modport execute (
        input  valid, pc, inst, rs1_value, rs2_value, imm, imm_kind,
               alu_op, src1_sel, src2_sel, rd, rd_wen,
        output ready
    );

endinterface

/* hw/reg_file.sv */
module reg_file #(
    parameter int data_w = rv_pkg::xlen,
    parameter int addr_w = rv_pkg::reg_addr_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] rs1_addr,
    input  logic [addr_w-1:0] rs2_addr,
    output logic [data_w-1:0] rs1_data,
    output logic [data_w-1:0] rs2_data,
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [data_w-1:0] wr_data
);
    localparam int nregs = 2 ** addr_w;

    logic [data_w-1:0] regs [1:nregs-1];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    a_wr_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> !$isunknown(wr_data)
    );

endmodule

/* hw/idu.sv */
module idu #(
    parameter int data_w = rv_pkg::xlen,
    parameter int addr_w = rv_pkg::reg_addr_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [data_w-1:0] in_pc,
    input  logic [data_w-1:0] in_inst,
    output logic [addr_w-1:0] rs1_addr,
    output logic [addr_w-1:0] rs2_addr,
    input  logic [data_w-1:0] rs1_data,
    input  logic [data_w-1:0] rs2_data,
    input  logic              fwd_valid,
    input  logic [addr_w-1:0] fwd_rd,
    input  logic [data_w-1:0] fwd_value,
    id_ex_if.decode           dec
);
    import rv_pkg::*;

    opcode_e           opcode;
    logic [2:0]        funct3;
    logic              funct7_alt;
    logic [addr_w-1:0] rd;
    logic              known;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic is_reg);
        case (f3)
            3'b000:  alu_decode = (alt && is_reg) ? alu_sub : alu_add;   // SUB exists only in OP
            3'b001:  alu_decode = alu_sll;
            3'b010:  alu_decode = alu_slt;
            3'b011:  alu_decode = alu_sltu;
            3'b100:  alu_decode = alu_xor;
            3'b101:  alu_decode = alt ? alu_sra : alu_srl;
            3'b110:  alu_decode = alu_or;
            default: alu_decode = alu_and;
        endcase
    endfunction

    assign opcode     = opcode_e'(in_inst[6:0]);
    assign funct3     = in_inst[14:12];
    assign funct7_alt = in_inst[30];
    assign rd         = in_inst[7 +: addr_w];
    assign rs1_addr   = in_inst[15 +: addr_w];
    assign rs2_addr   = in_inst[20 +: addr_w];

    always_comb begin
        known        = 1'b1;
        dec.alu_op   = alu_add;
        dec.imm_kind = imm_none;
        dec.src1_sel = src1_rs1;
        dec.src2_sel = src2_rs2;
        case (opcode)
            op_lui: begin
                dec.imm_kind = imm_u20;
                dec.src1_sel = src1_zero;
                dec.src2_sel = src2_imm;
            end
            op_auipc: begin
                dec.imm_kind = imm_u20;
                dec.src1_sel = src1_pc;
                dec.src2_sel = src2_imm;
            end
            op_imm: begin
                dec.alu_op   = alu_decode(funct3, funct7_alt, 1'b0);
                dec.imm_kind = (funct3[1:0] == 2'b01) ? imm_sh5 : imm_i12;
                dec.src2_sel = src2_imm;
            end
            op_reg: begin
                dec.alu_op = alu_decode(funct3, funct7_alt, 1'b1);
            end
            default: known = 1'b0;    // Unknown opcode becomes a no-op
        endcase
    end

    // Newest value sits in the execute register until it is written back
    assign dec.rs1_value = (rs1_addr != '0 && fwd_valid && fwd_rd == rs1_addr) ?
                           fwd_value : rs1_data;
    assign dec.rs2_value = (rs2_addr != '0 && fwd_valid && fwd_rd == rs2_addr) ?
                           fwd_value : rs2_data;

    assign dec.valid  = in_valid;
    assign in_ready   = dec.ready;
    assign dec.pc     = in_pc;
    assign dec.inst   = in_inst;
    assign dec.imm    = {{(data_w-20){1'b0}}, in_inst[31:12]};
    assign dec.rd     = rd;
    assign dec.rd_wen = known && rd != '0;

    a_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_inst) && $stable(in_pc)
    );

endmodule

/* hw/alu.sv */
module alu #(
    parameter int data_w = rv_pkg::xlen
) (
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    input  rv_pkg::alu_op_e   op,
    output logic [data_w-1:0] res
);
    import rv_pkg::*;

    localparam int sh_w = $clog2(data_w);

    logic [sh_w-1:0] shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign shamt       = b[sh_w-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  res = a + b;
            alu_sub:  res = a - b;
            alu_sll:  res = a << shamt;
            alu_slt:  res = {{(data_w-1){1'b0}}, lt_signed};
            alu_sltu: res = {{(data_w-1){1'b0}}, lt_unsigned};
            alu_xor:  res = a ^ b;
            alu_srl:  res = a >> shamt;
            alu_sra:  res = $unsigned($signed(a) >>> shamt);
            alu_or:   res = a | b;
            alu_and:  res = a & b;
            default:  res = '0;
        endcase
    end

endmodule

/* hw/exu.sv */
module exu #(
    parameter int data_w = rv_pkg::xlen,
    parameter int addr_w = rv_pkg::reg_addr_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    id_ex_if.execute          dec,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [data_w-1:0] out_pc,
    output logic [data_w-1:0] out_inst,
    output logic [data_w-1:0] out_value,
    output logic [addr_w-1:0] out_rd,
    output logic              out_wen,
    output logic              wr_en,
    output logic [addr_w-1:0] wr_addr,
    output logic [data_w-1:0] wr_data,
    output logic              fwd_valid,
    output logic [addr_w-1:0] fwd_rd,
    output logic [data_w-1:0] fwd_value
);
    import rv_pkg::*;

    logic              in_xfer;
    logic [data_w-1:0] pc_q;
    logic [data_w-1:0] inst_q;
    logic [data_w-1:0] rs1_q;
    logic [data_w-1:0] rs2_q;
    logic [data_w-1:0] imm_q;
    imm_kind_e         imm_kind_q;
    alu_op_e           alu_op_q;
    src1_sel_e         src1_sel_q;
    src2_sel_e         src2_sel_q;
    logic [addr_w-1:0] rd_q;
    logic              wen_q;
    logic [data_w-1:0] imm_val;
    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] alu_res;

    assign dec.ready = out_ready;           // Stage only advances when downstream takes
    assign in_xfer   = dec.valid && dec.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            wen_q     <= 1'b0;
        end else if (out_ready) begin
            out_valid <= dec.valid && !flush;
            if (in_xfer) begin
                wen_q <= dec.rd_wen && !flush;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q       <= '0;
            inst_q     <= '0;
            rs1_q      <= '0;
            rs2_q      <= '0;
            imm_q      <= '0;
            imm_kind_q <= imm_i12;
            alu_op_q   <= alu_add;
            src1_sel_q <= src1_rs1;
            src2_sel_q <= src2_imm;
            rd_q       <= '0;
        end else if (in_xfer) begin
            pc_q       <= dec.pc;
            inst_q     <= dec.inst;
            rs1_q      <= dec.rs1_value;
            rs2_q      <= dec.rs2_value;
            imm_q      <= dec.imm;
            imm_kind_q <= dec.imm_kind;
            alu_op_q   <= dec.alu_op;
            src1_sel_q <= dec.src1_sel;
            src2_sel_q <= dec.src2_sel;
            rd_q       <= dec.rd;
        end
    end

    always_comb begin
        case (imm_kind_q)
            imm_i12: imm_val = {{(data_w-12){imm_q[19]}}, imm_q[19:8]};
            imm_u20: imm_val = imm_q << 12;
            imm_sh5: imm_val = {{(data_w-5){1'b0}}, imm_q[12:8]};
            default: imm_val = '0;
        endcase
    end

    always_comb begin
        case (src1_sel_q)
            src1_rs1: op_a = rs1_q;
            src1_pc:  op_a = pc_q;
            default:  op_a = '0;
        endcase
    end

    assign op_b = (src2_sel_q == src2_rs2) ? rs2_q : imm_val;

    alu #(
        .data_w(data_w)
    ) u_alu (
        .a  (op_a),
        .b  (op_b),
        .op (alu_op_q),
        .res(alu_res)
    );

    assign out_pc    = pc_q;
    assign out_inst  = inst_q;
    assign out_value = alu_res;
    assign out_rd    = rd_q;
    assign out_wen   = wen_q;

    assign wr_en     = out_valid && out_ready && out_wen;
    assign wr_addr   = rd_q;
    assign wr_data   = alu_res;

    assign fwd_valid = out_valid && out_wen;
    assign fwd_rd    = rd_q;
    assign fwd_value = alu_res;

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_value) && $stable(out_rd)
    );

    // The decoder never lets a write target x0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr != '0
    );

endmodule

/* hw/ex_core.sv */
module ex_core #(
    parameter int data_w = rv_pkg::xlen,
    parameter int addr_w = rv_pkg::reg_addr_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [data_w-1:0] in_pc,
    input  logic [data_w-1:0] in_inst,
    input  logic              flush,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [data_w-1:0] out_pc,
    output logic [data_w-1:0] out_inst,
    output logic [addr_w-1:0] out_rd,
    output logic              out_wen,
    output logic [data_w-1:0] out_value
);
    logic [addr_w-1:0] rs1_addr;
    logic [addr_w-1:0] rs2_addr;
    logic [data_w-1:0] rs1_data;
    logic [data_w-1:0] rs2_data;
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;
    logic              fwd_valid;
    logic [addr_w-1:0] fwd_rd;
    logic [data_w-1:0] fwd_value;

    id_ex_if #(.data_w(data_w), .addr_w(addr_w)) u_id_ex ();

    idu #(.data_w(data_w), .addr_w(addr_w)) u_idu (
        .clk, .rst_n, .in_valid, .in_ready, .in_pc, .in_inst,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .fwd_valid, .fwd_rd, .fwd_value,
        .dec(u_id_ex.decode)
    );

    reg_file #(.data_w(data_w), .addr_w(addr_w)) u_reg_file (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr_en, .wr_addr, .wr_data
    );

    exu #(.data_w(data_w), .addr_w(addr_w)) u_exu (
        .clk, .rst_n, .flush,
        .dec(u_id_ex.execute),
        .out_valid, .out_ready, .out_pc, .out_inst, .out_value, .out_rd, .out_wen,
        .wr_en, .wr_addr, .wr_data,
        .fwd_valid, .fwd_rd, .fwd_value
    );

endmodule

/* bench/tb_ex_core.sv */
module tb_ex_core;

    localparam int send_limit  = 100;
    localparam int drain_limit = 400;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_pc;
    logic [31:0] in_inst;
    logic        flush;
    logic        out_valid;
    logic        out_ready = 1'b1;
    logic [31:0] out_pc;
    logic [31:0] out_inst;
    logic [4:0]  out_rd;
    logic        out_wen;
    logic [31:0] out_value;

    logic [31:0] lfsr     = 32'hccf42e74;
    logic [31:0] rdy_lfsr = 32'hccf42e74;
    logic [31:0] shadow [0:31] = '{default: '0};
    logic [31:0] q_inst [$];
    logic [31:0] q_pc [$];
    logic        exp_valid = 1'b0;
    logic [31:0] exp_inst;
    logic [31:0] exp_pc;
    logic [31:0] exp_value;
    logic [4:0]  exp_rd;
    logic        exp_wen;
    logic        xfer_out;
    logic        stall_mode;
    logic [31:0] pc;
    int          n_in = 0;
    int          n_out = 0;
    int          check_errs = 0;
    int          run_errs;
    int          tests_ok;
    int          tests_bad;

    ex_core #(.data_w(32), .addr_w(5)) u_ex_core (.*);

    always #50 clk = ~clk;

    // Random stretches of back-pressure when stall_mode is set
    always @(posedge clk) begin
        #1;
        if (stall_mode) begin
            rdy_lfsr  = lfsr_step(rdy_lfsr);
            out_ready = rdy_lfsr[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] v;
        v = rand_bits(5);
        return (v[4:0] == 5'd0) ? 5'd1 : v[4:0];
    endfunction

    function automatic int total_errs();
        return check_errs + run_errs;
    endfunction

    // Architectural result of one instruction from the RV32I rules
    function automatic logic [31:0] predict(input logic [31:0] inst, input logic [31:0] ipc);
        logic [31:0] a;
        logic [31:0] b;
        logic        is_reg;
        a      = shadow[inst[19:15]];
        is_reg = inst[6:0] == 7'b0110011;
        b      = is_reg ? shadow[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
        if (inst[6:0] == 7'b0110111) return {inst[31:12], 12'b0};
        if (inst[6:0] == 7'b0010111) return ipc + {inst[31:12], 12'b0};
        case (inst[14:12])
            3'b000:  return (is_reg && inst[30]) ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return inst[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("Fail %s expected %h actual %h", name, expv, actv);
        check_errs++;
    endtask

    task automatic send(input logic [31:0] inst, input logic fl);
        int waited;
        in_valid = 1'b1;
        in_inst  = inst;
        in_pc    = pc;
        flush    = fl;
        waited   = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!in_ready && waited < send_limit);
        if (!in_ready) begin
            $display("Timeout: instruction at pc %h was never accepted", pc);
            run_errs++;
        end
        #1;
        in_valid = 1'b0;
        flush    = 1'b0;
        pc       = pc + 32'd4;
    endtask

    // Bit 3 of k picks R or I form, bit 4 the SUB/SRA variant
    task automatic send_alu(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2);
        logic [2:0]  f3;
        logic [31:0] v;
        f3 = k[2:0];
        v  = rand_bits(12);
        if (k[3]) begin
            send({1'b0, k[4] && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd,
                  7'b0110011}, 1'b0);
        end else if (f3 == 3'b001 || f3 == 3'b101) begin
            send({1'b0, k[4] && f3 == 3'b101, 5'b0, v[4:0], rs1, f3, rd, 7'b0010011}, 1'b0);
        end else begin
            send({v[11:0], rs1, f3, rd, 7'b0010011}, 1'b0);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (q_inst.size() != 0 && waited < drain_limit);
        if (q_inst.size() != 0) begin
            $display("Timeout: no output arrived for %0d instructions", q_inst.size());
            run_errs++;
        end
        if (total_errs() == errs_before) begin
            tests_ok++;
            $display("Test %s finished without errors", name);
        end else begin
            tests_bad++;
            $display("Test %s finished with %0d errors", name, total_errs() - errs_before);
        end
    endtask

    assign xfer_out = out_valid && out_ready;

    // Shadow registers follow the results in output order
    always @(posedge clk) begin
        if (rst_n) begin
            if (xfer_out) begin
                n_out++;
                if (exp_valid) begin
                    if (exp_wen) begin
                        shadow[exp_rd] = exp_value;
                    end
                    exp_inst = q_inst.pop_front();
                    exp_pc   = q_pc.pop_front();
                end
            end
            if (in_valid && in_ready && !flush) begin
                q_inst.push_back(in_inst);
                q_pc.push_back(in_pc);
                n_in++;
            end
            exp_valid = q_inst.size() > 0;
            if (exp_valid) begin
                exp_inst  = q_inst[0];
                exp_pc    = q_pc[0];
                exp_rd    = exp_inst[11:7];
                exp_wen   = exp_rd != 5'd0;
                exp_value = predict(exp_inst, exp_pc);
            end
        end
    end

    a_expected: assert property (@(posedge clk) disable iff (!rst_n) xfer_out |-> exp_valid)
        else begin
            $display("Output transfer arrived with no instruction pending");
            check_errs++;
        end
    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_out && exp_valid |-> out_value == exp_value)
        else report_mismatch("out_value", $sampled(exp_value), $sampled(out_value));
    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_out && exp_valid |-> out_pc == exp_pc)
        else report_mismatch("out_pc", $sampled(exp_pc), $sampled(out_pc));
    a_inst: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_out && exp_valid |-> out_inst == exp_inst)
        else report_mismatch("out_inst", $sampled(exp_inst), $sampled(out_inst));
    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
        xfer_out && exp_valid |-> out_rd == exp_rd && out_wen == exp_wen)
        else report_mismatch("out_rd/out_wen", 32'({$sampled(exp_rd), $sampled(exp_wen)}),
                             32'({$sampled(out_rd), $sampled(out_wen)}));
    a_stall_ready: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |-> !in_ready)
        else begin
            $display("Input was ready while the output was stalled");
            check_errs++;
        end
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_value))
        else begin
            $display("Output changed while it was stalled");
            check_errs++;
        end

    initial begin
        int          e0;
        logic [4:0]  r;
        logic [4:0]  prev;
        logic [31:0] v;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_pc      = '0;
        in_inst    = '0;
        flush      = 1'b0;
        stall_mode = 1'b0;
        pc         = 32'h0000_1000;
        run_errs   = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        e0 = total_errs();
        for (int i = 1; i < 32; i++) begin
            v = rand_bits(32);
            send({v[31:12], 5'(i), 7'b0110111}, 1'b0);
            send({v[11:0], 5'(i), 3'b000, 5'(i), 7'b0010011}, 1'b0);
        end
        finish_test("lui_addi", e0);

        e0 = total_errs();
        for (int k = 0; k < 64; k++) begin
            send_alu(k, rand_reg(), rand_reg(), rand_reg());
        end
        finish_test("alu_ops", e0);

        e0   = total_errs();
        prev = rand_reg();
        for (int i = 0; i < 24; i++) begin
            r = rand_reg();
            send_alu(i, r, prev, i[1] ? prev : rand_reg());
            prev = r;
        end
        send({12'h7ff, prev, 3'b000, 5'd0, 7'b0010011}, 1'b0);    // Result has to vanish
        send({1'b0, 1'b0, 5'b0, 5'd0, 5'd0, 3'b000, prev, 7'b0110011}, 1'b0);
        finish_test("forwarding", e0);

        e0         = total_errs();
        stall_mode = 1'b1;
        for (int i = 0; i < 40; i++) begin
            r = rand_reg();
            send_alu(i, r, prev, rand_reg());
            prev = r;
        end
        finish_test("backpressure", e0);
        stall_mode = 1'b0;
        if (n_in != n_out) begin
            $display("Output count %0d does not match input count %0d", n_out, n_in);
            run_errs++;
        end

        e0 = total_errs();
        for (int i = 0; i < 6; i++) begin
            r = rand_reg();
            v = rand_bits(12);
            send({v[11:0], 5'd0, 3'b000, r, 7'b0010011}, 1'b1);
            send({1'b0, 1'b0, 5'b0, 5'd0, r, 3'b000, prev, 7'b0110011}, 1'b0);   // Old value of r
        end
        finish_test("flush", e0);

        e0 = total_errs();
        for (int i = 0; i < 8; i++) begin
            v  = rand_bits(30);
            pc = {v[29:0], 2'b00};
            v  = rand_bits(20);
            send({v[19:0], rand_reg(), 7'b0010111}, 1'b0);
        end
        finish_test("auipc", e0);

        $display("Tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, total_errs());
        if (total_errs() == 0 && tests_bad == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
hw/rv_pkg.sv
hw/id_ex_if.sv
hw/reg_file.sv
hw/idu.sv
hw/alu.sv
hw/exu.sv
hw/ex_core.sv
bench/tb_ex_core.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f all.f --top-module tb_ex_core -o sim_ex_core &&
./obj_dir/sim_ex_core | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
